// File: all.f
lsPkg.sv
memBus.sv
lsIssueBus.sv
lsQueue.sv
loadStoreUnit.sv
fetchUnit.sv
memArbiter.sv
dataMemory.sv
lsTop.sv
lsTop_assertions.sv
tb_lsTop.sv

// File: dataMemory.sv
`timescale 1ns/10ps

module dataMemory import lsPkg::*; (
    input logic  clk,
    memBus.slave bus
);

    logic [DataWidth-1:0]          ram [MemWords];
    logic [DataWidth-1:0]          dataPipe [MemLatency];
    logic [MemLatency-1:0]         validPipe;
    logic [$clog2(MemWords)-1:0]   wordIdx;
    logic                          accept;

    assign bus.reqReady = 1'b1;  // never stalls
    assign accept       = bus.reqValid && bus.reqReady;
    assign wordIdx      = bus.reqAddr[$clog2(MemWords)+1:2];

    always_ff @(posedge clk) begin
        if (accept && bus.reqWrite) begin
            for (int b = 0; b < DataWidth/8; b++) begin
                if (bus.reqByteEn[b])
                    ram[wordIdx][b*8 +: 8] <= bus.reqData[b*8 +: 8];
            end
        end
    end

    // read pipeline, a write returns the word before the update
    always_ff @(posedge clk) begin
        validPipe   <= {validPipe[MemLatency-2:0], accept};
        dataPipe[0] <= ram[wordIdx];
        for (int s = 1; s < MemLatency; s++) begin
            dataPipe[s] <= dataPipe[s-1];
        end
    end

    assign bus.respValid = validPipe[MemLatency-1];
    assign bus.respData  = dataPipe[MemLatency-1];

endmodule

// File: fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit import lsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 redirectValid,
    input  logic [AddrWidth-1:0] redirectPc,
    memBus.master                mem,
    output logic                 fetchValid,
    input  logic                 fetchReady,
    output logic [AddrWidth-1:0] fetchPc,
    output logic [DataWidth-1:0] fetchInstr
);

    logic [AddrWidth-1:0] pc;
    logic                 running;  // set by the first redirect
    logic                 waiting;
    logic                 stale;    // outstanding read belongs to an old pc
    logic                 startReq;
    logic                 gotResp;

    assign startReq = running && !redirectValid && !mem.reqValid && !waiting && !fetchValid;
    assign gotResp  = waiting && mem.respValid;

    assign fetchPc       = pc;
    assign mem.reqWrite  = 1'b0;
    assign mem.reqByteEn = '1;
    assign mem.reqData   = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc           <= '0;
            running      <= 1'b0;
            waiting      <= 1'b0;
            stale        <= 1'b0;
            fetchValid   <= 1'b0;
            mem.reqValid <= 1'b0;
        end else begin
            if (startReq) begin
                mem.reqValid <= 1'b1;
            end else if (mem.reqValid && mem.reqReady) begin
                mem.reqValid <= 1'b0;
                waiting      <= 1'b1;
            end
            if (gotResp) begin
                waiting    <= 1'b0;
                stale      <= 1'b0;
                fetchValid <= !stale;
            end
            if (fetchValid && fetchReady) begin
                fetchValid <= 1'b0;
                pc         <= pc + AddrWidth'(4);
            end
            if (redirectValid) begin
                pc         <= redirectPc;
                running    <= 1'b1;
                fetchValid <= 1'b0;
                stale      <= mem.reqValid || (waiting && !mem.respValid);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startReq)
            mem.reqAddr <= {pc[AddrWidth-1:2], 2'b00};
        if (gotResp)
            fetchInstr <= mem.respData;
    end

endmodule

// File: loadStoreUnit.sv
`timescale 1ns/10ps

module loadStoreUnit import lsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    lsIssueBus.sink              in,
    memBus.master                mem,
    output logic                 resultValid,
    output logic [DataWidth-1:0] resultData,
    output logic [TagWidth-1:0]  resultTag
);

    logic                   busy;
    logic                   take;
    logic                   respTaken;
    logic [AddrWidth-1:0]   effAddr;
    logic [1:0]             laneSel;
    logic [DataWidth/8-1:0] laneEn;
    memWord_u               storeWord;
    memWord_u               respWord;
    lsOp_e                  opReg;
    logic [1:0]             laneReg;
    logic [TagWidth-1:0]    tagReg;
    logic [DataWidth-1:0]   loadValue;

    assign in.ready  = !busy;
    assign take      = in.valid && !busy;
    assign respTaken = busy && !mem.reqValid && mem.respValid;  // request already gone

    assign effAddr = in.base + in.offset;
    assign laneSel = effAddr[1:0];

    // byte enables and store data moved into its lane
    always_comb begin
        storeWord = '0;
        laneEn    = '0;
        case (in.op)
            SB: begin
                storeWord.bytes[laneSel] = in.storeData[7:0];
                laneEn[laneSel]          = 1'b1;
            end
            SH: begin
                storeWord.halves[laneSel[1]] = in.storeData[15:0];
                laneEn = laneSel[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                storeWord = in.storeData;
                laneEn    = '1;
            end
            default: laneEn = '1;  // loads read the full word
        endcase
    end

    assign respWord = mem.respData;

    always_comb begin
        case (opReg)
            LB:  loadValue = {{(DataWidth-8){respWord.bytes[laneReg][7]}},
                              respWord.bytes[laneReg]};
            LBU: loadValue = {{(DataWidth-8){1'b0}}, respWord.bytes[laneReg]};
            LH:  loadValue = {{(DataWidth-16){respWord.halves[laneReg[1]][15]}},
                              respWord.halves[laneReg[1]]};
            LHU: loadValue = {{(DataWidth-16){1'b0}}, respWord.halves[laneReg[1]]};
            default: loadValue = respWord;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            mem.reqValid <= 1'b0;
            resultValid  <= 1'b0;
        end else begin
            resultValid <= 1'b0;  // single cycle pulse
            if (take) begin
                busy         <= 1'b1;
                mem.reqValid <= 1'b1;
            end else if (mem.reqValid && mem.reqReady) begin
                mem.reqValid <= 1'b0;
            end else if (respTaken) begin
                busy        <= 1'b0;
                resultValid <= !(opReg inside {SB, SH, SW});  // stores end silently
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem.reqWrite  <= in.op inside {SB, SH, SW};
            mem.reqAddr   <= {effAddr[AddrWidth-1:2], 2'b00};
            mem.reqByteEn <= laneEn;
            mem.reqData   <= storeWord;
            opReg         <= in.op;
            laneReg       <= laneSel;
            tagReg        <= in.tag;
        end
        if (respTaken) begin
            resultData <= loadValue;
            resultTag  <= tagReg;
        end
    end

endmodule

// File: lsIssueBus.sv
`timescale 1ns/10ps

interface lsIssueBus import lsPkg::*; ();

    logic                 valid;
    logic                 ready;
    lsOp_e                op;
    logic [AddrWidth-1:0] base;
    logic [AddrWidth-1:0] offset;
    logic [DataWidth-1:0] storeData;
    logic [TagWidth-1:0]  tag;

    modport source (
        output valid, op, base, offset, storeData, tag,
        input  ready
    );

    modport sink (
        input  valid, op, base, offset, storeData, tag,
        output ready
    );

endinterface

// File: lsPkg.sv
package lsPkg;

    localparam int DataWidth  = 32;
    localparam int AddrWidth  = 32;
    localparam int TagWidth   = 4;
    localparam int MemWords   = 256;  // 1 KiB, upper address bits ignored
    localparam int QueueDepth = 4;
    localparam int MemLatency = 2;    // request edge to response edge

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } lsOp_e;

    // one memory word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } memWord_u;

endpackage

// File: lsQueue.sv
`timescale 1ns/10ps

module lsQueue import lsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueValid,
    output logic                 issueReady,
    input  lsOp_e                issueOp,
    input  logic [AddrWidth-1:0] issueBase,
    input  logic [AddrWidth-1:0] issueOffset,
    input  logic [DataWidth-1:0] issueStoreData,
    input  logic [TagWidth-1:0]  issueTag,
    lsIssueBus.source            out
);

    lsOp_e                opMem    [QueueDepth];
    logic [AddrWidth-1:0] baseMem  [QueueDepth];
    logic [AddrWidth-1:0] offMem   [QueueDepth];
    logic [DataWidth-1:0] dataMem  [QueueDepth];
    logic [TagWidth-1:0]  tagMem   [QueueDepth];

    logic [$clog2(QueueDepth)-1:0] wrPtr;
    logic [$clog2(QueueDepth)-1:0] rdPtr;
    logic [$clog2(QueueDepth):0]   count;
    logic [$clog2(QueueDepth):0]   countNext;
    logic                          push;
    logic                          pop;

    assign push = issueValid && issueReady;
    assign pop  = out.valid && out.ready;

    always_comb begin
        countNext = count;
        if (push && !pop)
            countNext = count + 1'b1;
        else if (pop && !push)
            countNext = count - 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            issueReady <= 1'b0;  // held low through reset
        end else begin
            if (push)
                wrPtr <= wrPtr + 1'b1;
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            count      <= countNext;
            issueReady <= (countNext != QueueDepth);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            opMem[wrPtr]   <= issueOp;
            baseMem[wrPtr] <= issueBase;
            offMem[wrPtr]  <= issueOffset;
            dataMem[wrPtr] <= issueStoreData;
            tagMem[wrPtr]  <= issueTag;
        end
    end

    // head entry, oldest in program order
    assign out.valid     = (count != 0);
    assign out.op        = opMem[rdPtr];
    assign out.base      = baseMem[rdPtr];
    assign out.offset    = offMem[rdPtr];
    assign out.storeData = dataMem[rdPtr];
    assign out.tag       = tagMem[rdPtr];

endmodule

// File: lsTop.sv
`timescale 1ns/10ps

module lsTop import lsPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueValid,
    output logic                 issueReady,
    input  lsOp_e                issueOp,
    input  logic [AddrWidth-1:0] issueBase,
    input  logic [AddrWidth-1:0] issueOffset,
    input  logic [DataWidth-1:0] issueStoreData,
    input  logic [TagWidth-1:0]  issueTag,
    input  logic                 redirectValid,
    input  logic [AddrWidth-1:0] redirectPc,
    output logic                 fetchValid,
    input  logic                 fetchReady,
    output logic [AddrWidth-1:0] fetchPc,
    output logic [DataWidth-1:0] fetchInstr,
    output logic                 resultValid,
    output logic [DataWidth-1:0] resultData,
    output logic [TagWidth-1:0]  resultTag
);

    lsIssueBus issueBus ();
    memBus     lsMemBus ();
    memBus     fetchMemBus ();
    memBus     ramBus ();

    lsQueue i_lsQueue (
        .clk            (clk),
        .rst            (rst),
        .issueValid     (issueValid),
        .issueReady     (issueReady),
        .issueOp        (issueOp),
        .issueBase      (issueBase),
        .issueOffset    (issueOffset),
        .issueStoreData (issueStoreData),
        .issueTag       (issueTag),
        .out            (issueBus)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk         (clk),
        .rst         (rst),
        .in          (issueBus),
        .mem         (lsMemBus),
        .resultValid (resultValid),
        .resultData  (resultData),
        .resultTag   (resultTag)
    );

    fetchUnit i_fetchUnit (
        .clk           (clk),
        .rst           (rst),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .mem           (fetchMemBus),
        .fetchValid    (fetchValid),
        .fetchReady    (fetchReady),
        .fetchPc       (fetchPc),
        .fetchInstr    (fetchInstr)
    );

    memArbiter i_memArbiter (
        .clk       (clk),
        .rst       (rst),
        .lsPort    (lsMemBus),
        .fetchPort (fetchMemBus),
        .mem       (ramBus)
    );

    dataMemory i_dataMemory (
        .clk (clk),
        .bus (ramBus)
    );

endmodule

// File: lsTop_assertions.sv
`timescale 1ns/10ps

module lsTop_assertions import lsPkg::*; (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 issueReady,
    input logic                                 resultValid,
    input logic [$clog2(QueueDepth):0]          queueCount,
    input logic [$clog2(MemLatency):0]          orderCount,
    input logic                                 ramRespValid,
    input logic                                 lsReqValid,
    input logic                                 lsReqReady,
    input logic [AddrWidth+DataWidth+DataWidth/8:0] lsReq,     // write, addr, byte enables, data
    input logic                                 fetchReqValid,
    input logic                                 fetchReqReady,
    input logic [AddrWidth+DataWidth+DataWidth/8:0] fetchReq
);

    int failures = 0;

    // held request must not move until accepted
    assert property (@(posedge clk) disable iff (rst)
        lsReqValid && !lsReqReady |=> lsReqValid && $stable(lsReq))
    else begin
        $error("load/store request changed before it was accepted");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst)
        fetchReqValid && !fetchReqReady |=> fetchReqValid && $stable(fetchReq))
    else begin
        $error("fetch request changed before it was accepted");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst) resultValid |=> !resultValid)
    else begin
        $error("resultValid lasted more than one cycle");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst) queueCount == QueueDepth |-> !issueReady)
    else begin
        $error("issueReady high while the queue is full");
        failures++;
    end

    assert property (@(posedge clk) disable iff (rst) ramRespValid |-> orderCount != 0)
    else begin
        $error("memory response with no owner recorded");
        failures++;
    end

endmodule

// File: ls_trace.txt
# I op base offset storeData tag expected (expected unused by stores) | R pc | F pc word, all hex
# a redirect waits until every earlier load result and expected fetch word has arrived
I SW 000000f0 00000010 12345678 1 00000000
I LW 00000100 00000000 00000000 2 12345678
I SW 00000104 00000000 aaaaaaaa 3 00000000
I SB 00000100 00000005 1234565c 4 00000000
I SH 00000100 00000006 0000beef 5 00000000
I LW 00000104 00000000 00000000 6 beef5caa
I SW 00000108 00000000 9abc80f3 7 00000000
I LB 00000108 00000000 00000000 8 fffffff3
I LBU 00000108 00000000 00000000 9 000000f3
I LB 00000108 00000001 00000000 a ffffff80
I LBU 0000010c ffffffff 00000000 b 0000009a
I LH 00000108 00000000 00000000 c ffff80f3
I LHU 00000108 00000000 00000000 d 000080f3
I LH 0000010a 00000000 00000000 e ffff9abc
I LHU 00000108 00000002 00000000 f 00009abc
I SW 00000200 00000000 00500093 0 00000000
I SW 00000200 00000004 00a00113 1 00000000
I SW 00000200 00000008 002081b3 2 00000000
I SW 00000200 0000000c 40110233 3 00000000
I LW 00000200 0000000c 00000000 4 40110233
I LW 00000200 00000000 00000000 5 00500093
R 00000200
F 00000200 00500093
F 00000204 00a00113
F 00000208 002081b3
F 0000020c 40110233
R 00000100
F 00000100 12345678
F 00000104 beef5caa
F 00000108 9abc80f3
I LW 00000204 00000000 00000000 6 00a00113
I LHU 0000020c 00000002 00000000 7 00004011
I SW 00000300 00000000 c0ffee11 8 00000000
I LB 00000200 00000000 00000000 9 ffffff93
I LW 00000400 00000300 00000000 a c0ffee11
I LW 000000fc 00000004 00000000 b 12345678

// File: memArbiter.sv
`timescale 1ns/10ps

module memArbiter import lsPkg::*; (
    input  logic  clk,
    input  logic  rst,
    memBus.slave  lsPort,
    memBus.slave  fetchPort,
    memBus.master mem
);

    logic                          lastFetch;  // fetch was served last
    logic                          grantFetch;
    logic                          canAccept;
    logic                          accepted;
    logic                          headFetch;
    logic                          owner [MemLatency];  // 1 marks a fetch request
    logic [$clog2(MemLatency)-1:0] ordWr;
    logic [$clog2(MemLatency)-1:0] ordRd;
    logic [$clog2(MemLatency):0]   orderCount;

    // round robin, the master not served last wins a tie
    assign grantFetch = fetchPort.reqValid && (!lsPort.reqValid || !lastFetch);
    assign canAccept  = (orderCount != MemLatency) || mem.respValid;

    assign mem.reqValid  = (lsPort.reqValid || fetchPort.reqValid) && canAccept;
    assign mem.reqWrite  = grantFetch ? fetchPort.reqWrite  : lsPort.reqWrite;
    assign mem.reqAddr   = grantFetch ? fetchPort.reqAddr   : lsPort.reqAddr;
    assign mem.reqByteEn = grantFetch ? fetchPort.reqByteEn : lsPort.reqByteEn;
    assign mem.reqData   = grantFetch ? fetchPort.reqData   : lsPort.reqData;

    assign lsPort.reqReady    = mem.reqReady && canAccept && !grantFetch;
    assign fetchPort.reqReady = mem.reqReady && canAccept && grantFetch;
    assign accepted           = mem.reqValid && mem.reqReady;

    // responses return in acceptance order
    assign headFetch           = owner[ordRd];
    assign lsPort.respValid    = mem.respValid && !headFetch;
    assign fetchPort.respValid = mem.respValid && headFetch;
    assign lsPort.respData     = mem.respData;
    assign fetchPort.respData  = mem.respData;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lastFetch  <= 1'b0;
            ordWr      <= '0;
            ordRd      <= '0;
            orderCount <= '0;
        end else begin
            if (accepted) begin
                lastFetch <= grantFetch;
                ordWr     <= ordWr + 1'b1;
            end
            if (mem.respValid)
                ordRd <= ordRd + 1'b1;
            if (accepted && !mem.respValid)
                orderCount <= orderCount + 1'b1;
            else if (mem.respValid && !accepted)
                orderCount <= orderCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accepted)
            owner[ordWr] <= grantFetch;
    end

endmodule

// File: memBus.sv
`timescale 1ns/10ps

interface memBus import lsPkg::*; ();

    logic                     reqValid;
    logic                     reqReady;
    logic                     reqWrite;
    logic [AddrWidth-1:0]     reqAddr;    // word aligned
    logic [DataWidth/8-1:0]   reqByteEn;
    logic [DataWidth-1:0]     reqData;
    logic                     respValid;  // one per accepted request, in order
    logic [DataWidth-1:0]     respData;

    modport master (
        output reqValid, reqWrite, reqAddr, reqByteEn, reqData,
        input  reqReady, respValid, respData
    );

    modport slave (
        input  reqValid, reqWrite, reqAddr, reqByteEn, reqData,
        output reqReady, respValid, respData
    );

endinterface

// File: tb_lsTop.sv
`timescale 1ns/10ps

module tb_lsTop import lsPkg::*; ();

    logic                 clk;
    logic                 rst;
    logic                 issueValid;
    logic                 issueReady;
    lsOp_e                issueOp;
    logic [AddrWidth-1:0] issueBase;
    logic [AddrWidth-1:0] issueOffset;
    logic [DataWidth-1:0] issueStoreData;
    logic [TagWidth-1:0]  issueTag;
    logic                 redirectValid;
    logic [AddrWidth-1:0] redirectPc;
    logic                 fetchValid;
    logic                 fetchReady;
    logic [AddrWidth-1:0] fetchPc;
    logic [DataWidth-1:0] fetchInstr;
    logic                 resultValid;
    logic [DataWidth-1:0] resultData;
    logic [TagWidth-1:0]  resultTag;

    logic [TagWidth-1:0]  expTag[$];   // pending loads in issue order
    logic [DataWidth-1:0] expData[$];
    logic [AddrWidth-1:0] expPc[$];    // pending fetch words
    logic [DataWidth-1:0] expWord[$];
    string                records[$];
    logic [TagWidth-1:0]  tagWant;
    logic [DataWidth-1:0] dataWant;
    logic [AddrWidth-1:0] pcWant;
    logic [DataWidth-1:0] wordWant;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    int                   cycleLimit = 100000;
    integer               seed = 32'h9c9a_1940;

    lsTop i_lsTop (.*);

    bind lsTop lsTop_assertions i_lsTopAssertions (
        .clk           (clk),
        .rst           (rst),
        .issueReady    (issueReady),
        .resultValid   (resultValid),
        .queueCount    (i_lsQueue.count),
        .orderCount    (i_memArbiter.orderCount),
        .ramRespValid  (ramBus.respValid),
        .lsReqValid    (lsMemBus.reqValid),
        .lsReqReady    (lsMemBus.reqReady),
        .lsReq         ({lsMemBus.reqWrite, lsMemBus.reqAddr,
                         lsMemBus.reqByteEn, lsMemBus.reqData}),
        .fetchReqValid (fetchMemBus.reqValid),
        .fetchReqReady (fetchMemBus.reqReady),
        .fetchReq      ({fetchMemBus.reqWrite, fetchMemBus.reqAddr,
                         fetchMemBus.reqByteEn, fetchMemBus.reqData})
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fetch back-pressure with ready about three cycles in four
    always @(posedge clk) begin
        #2;
        fetchReady = ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            errors++;
            $display("timeout: the trace did not finish within %0d cycles", cycleLimit);
            endRun();
        end
    end

    always @(negedge clk) begin
        if (!rst && resultValid) begin
            if (expTag.size() == 0) begin
                errors++;
                $display("error at %0d ns: a load result arrived with no load pending", $time);
            end else begin
                tagWant  = expTag.pop_front();
                dataWant = expData.pop_front();
                checks++;
                if (resultTag !== tagWant) begin
                    errors++;
                    $display("error at %0d ns: resultTag expected %h, got %h",
                             $time, tagWant, resultTag);
                end
                if (resultData !== dataWant) begin
                    errors++;
                    $display("error at %0d ns: resultData expected %h, got %h",
                             $time, dataWant, resultData);
                end
            end
        end
    end

    // fetch keeps running so words past the expected ones are ignored
    always @(negedge clk) begin
        if (!rst && fetchValid && fetchReady && expPc.size() != 0) begin
            pcWant   = expPc.pop_front();
            wordWant = expWord.pop_front();
            checks++;
            if (fetchPc !== pcWant) begin
                errors++;
                $display("error at %0d ns: fetchPc expected %h, got %h", $time, pcWant, fetchPc);
            end
            if (fetchInstr !== wordWant) begin
                errors++;
                $display("error at %0d ns: fetchInstr expected %h, got %h",
                         $time, wordWant, fetchInstr);
            end
        end
    end

    task automatic checkBit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0d ns: %s expected %b, got %b", $time, name, want, got);
        end
    endtask

    function automatic bit parseOp(input string name, output lsOp_e op);
        parseOp = 1'b1;
        op      = LB;
        case (name)
            "LB":    op = LB;
            "LH":    op = LH;
            "LW":    op = LW;
            "LBU":   op = LBU;
            "LHU":   op = LHU;
            "SB":    op = SB;
            "SH":    op = SH;
            "SW":    op = SW;
            default: parseOp = 1'b0;
        endcase
    endfunction

    task automatic readTrace();
        int    fd;
        string line;
        fd = $fopen("ls_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the trace file ls_trace.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
                records.push_back(line);
        end
        $fclose(fd);
    endtask

    task automatic sendIssue(input lsOp_e op, input logic [AddrWidth-1:0] base,
                             input logic [AddrWidth-1:0] offset,
                             input logic [DataWidth-1:0] data, input logic [TagWidth-1:0] tag);
        issueValid     = 1'b1;
        issueOp        = op;
        issueBase      = base;
        issueOffset    = offset;
        issueStoreData = data;
        issueTag       = tag;
        @(negedge clk);
        while (!issueReady)
            @(negedge clk);
        @(posedge clk);  // transfer edge
        #2;
        issueValid = 1'b0;
    endtask

    task automatic waitIdle();
        while (expTag.size() != 0 || expPc.size() != 0)
            @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic sendRedirect(input logic [AddrWidth-1:0] pc);
        redirectValid = 1'b1;
        redirectPc    = pc;
        @(posedge clk);
        #2;
        redirectValid = 1'b0;
    endtask

    task automatic runRecord(input string line);
        string                kind;
        string                opName;
        lsOp_e                op;
        logic [AddrWidth-1:0] addr;
        logic [AddrWidth-1:0] offset;
        logic [DataWidth-1:0] data;
        logic [DataWidth-1:0] want;
        logic [TagWidth-1:0]  tag;
        if ($sscanf(line, "%s", kind) < 1)
            return;
        if (kind == "I") begin
            if ($sscanf(line, "%s %s %h %h %h %h %h", kind, opName, addr, offset, data, tag,
                        want) != 7 || !parseOp(opName, op)) begin
                errors++;
                $display("bad issue record in the trace: %s", line);
            end else begin
                if (!(op inside {SB, SH, SW})) begin  // stores give no result
                    expTag.push_back(tag);
                    expData.push_back(want);
                end
                sendIssue(op, addr, offset, data, tag);
            end
        end else if (kind == "R") begin
            if ($sscanf(line, "%s %h", kind, addr) != 2) begin
                errors++;
                $display("bad redirect record in the trace: %s", line);
            end else begin
                waitIdle();  // stored words must be in memory first
                sendRedirect(addr);
            end
        end else if (kind == "F") begin
            if ($sscanf(line, "%s %h %h", kind, addr, want) != 3) begin
                errors++;
                $display("bad fetch record in the trace: %s", line);
            end else begin
                expPc.push_back(addr);
                expWord.push_back(want);
            end
        end else begin
            errors++;
            $display("unknown record in the trace: %s", line);
        end
    endtask

    task automatic endRun();
        errors += i_lsTop.i_lsTopAssertions.failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, i_lsTop.i_lsTopAssertions.failures);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    initial begin
        rst            = 1'b1;
        issueValid     = 1'b0;
        issueOp        = LB;
        issueBase      = '0;
        issueOffset    = '0;
        issueStoreData = '0;
        issueTag       = '0;
        redirectValid  = 1'b0;
        redirectPc     = '0;
        fetchReady     = 1'b0;
        readTrace();
        cycleLimit = 40 * records.size() + 200;
        repeat (15) @(posedge clk);
        @(negedge clk);
        checkBit("issueReady", issueReady, 1'b0);
        checkBit("resultValid", resultValid, 1'b0);
        checkBit("fetchValid", fetchValid, 1'b0);
        @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (records[i])
            runRecord(records[i]);
        waitIdle();
        repeat (10) @(posedge clk);  // room for a stray result
        if (records.size() == 0) begin
            errors++;
            $display("the trace gave no records");
        end
        endRun();
    end

endmodule
